//--- rtl/memCtrlPkg.sv
package memCtrlPkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int BYTE_W = 8;
    localparam int WORD_W = 32;

    // bytes in one instruction or data word
    localparam int WORD_BYTES = 4;

    // wide enough to count up to WORD_BYTES
    localparam int LEN_W = 3;

    typedef enum logic {
        opLoad,
        opStore
    } accessOp_t;

    // value is the number of bytes moved
    typedef enum logic [LEN_W-1:0] {
        lenByte = 3'd1,
        lenHalf = 3'd2,
        lenWord = 3'd4
    } accessLen_t;

    // current owner of the RAM port
    typedef enum logic [1:0] {
        ownNone,
        ownData,
        ownFetch
    } owner_t;

endpackage

//--- rtl/ramBusIf.sv
interface ramBusIf
    import memCtrlPkg::*;
();

    // requester to arbiter
    logic              req;
    logic              last;
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [BYTE_W-1:0] wdata;

    // arbiter to requester
    logic              gnt;
    logic [BYTE_W-1:0] rdata;

    modport requester (
        output req,
        output last,
        output write,
        output addr,
        output wdata,
        input  gnt,
        input  rdata
    );

    modport arbiter (
        input  req,
        input  last,
        input  write,
        input  addr,
        input  wdata,
        output gnt,
        output rdata
    );

endinterface

//--- rtl/fetchUnit.sv
module fetchUnit
    import memCtrlPkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              i_req,
    input  logic [ADDR_W-1:0] i_addr,
    output logic              o_done,
    output logic [WORD_W-1:0] o_inst,
    ramBusIf.requester        bus
);

    logic                              busy;
    logic [ADDR_W-1:0]                 baseAddr;
    logic [LEN_W-1:0]                  beat;
    logic                              inFlight;
    logic [(WORD_BYTES-1)*BYTE_W-1:0]  byteStore;
    logic                              start;
    logic                              closing;
    logic                              beatDone;

    // the cycle of done still sees the old request
    assign start    = i_req && !busy && !o_done;
    // beat after the four reads issues nothing
    assign closing  = (beat == LEN_W'(WORD_BYTES));
    assign beatDone = busy && bus.gnt;

    assign bus.req   = busy;
    assign bus.last  = busy && closing;
    assign bus.write = 1'b0;
    assign bus.addr  = baseAddr + ADDR_W'(beat);
    assign bus.wdata = '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            beat     <= '0;
            inFlight <= 1'b0;
            o_done   <= 1'b0;
        end else begin
            // read data shows up one cycle after a granted beat
            inFlight <= beatDone && !closing;
            o_done   <= beatDone && closing;
            if (start) begin
                busy <= 1'b1;
                beat <= '0;
            end else if (beatDone) begin
                if (closing) begin
                    busy <= 1'b0;
                end else begin
                    beat <= beat + LEN_W'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            baseAddr <= i_addr;
        end
        if (inFlight) begin
            if (closing) begin
                // top byte arrives while the closing beat is pending
                o_inst <= {bus.rdata, byteStore};
            end else begin
                byteStore <= {bus.rdata, byteStore[(WORD_BYTES-1)*BYTE_W-1:BYTE_W]};
            end
        end
    end

endmodule

//--- rtl/dataUnit.sv
module dataUnit
    import memCtrlPkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              i_req,
    input  accessOp_t         i_op,
    input  accessLen_t        i_len,
    input  logic [ADDR_W-1:0] i_addr,
    input  logic [WORD_W-1:0] i_wdata,
    output logic              o_done,
    output logic [WORD_W-1:0] o_rdata,
    ramBusIf.requester        bus
);

    logic              busy;
    accessOp_t         opReg;
    accessLen_t        lenReg;
    logic [ADDR_W-1:0] baseAddr;
    logic [WORD_W-1:0] wdataReg;
    logic [LEN_W-1:0]  beat;
    logic [LEN_W-1:0]  capLane;
    logic              inFlight;
    logic              isStore;
    logic              finalBeat;
    logic              start;
    logic              beatDone;

    assign start    = i_req && !busy && !o_done;
    assign isStore  = (opReg == opStore);
    assign beatDone = busy && bus.gnt;

    // store ends on its last write, load one beat after its last read
    assign finalBeat = isStore ? (beat + LEN_W'(1) == LEN_W'(lenReg))
                               : (beat == LEN_W'(lenReg));

    // lane of the byte that is returning this cycle
    assign capLane = beat - LEN_W'(1);

    assign bus.req   = busy;
    assign bus.last  = busy && finalBeat;
    assign bus.write = busy && isStore;
    assign bus.addr  = baseAddr + ADDR_W'(beat);
    assign bus.wdata = BYTE_W'(wdataReg >> (BYTE_W * beat));

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            beat     <= '0;
            inFlight <= 1'b0;
            o_done   <= 1'b0;
        end else begin
            inFlight <= beatDone && !finalBeat && !isStore;
            o_done   <= beatDone && finalBeat;
            if (start) begin
                busy <= 1'b1;
                beat <= '0;
            end else if (beatDone) begin
                if (finalBeat) begin
                    busy <= 1'b0;
                end else begin
                    beat <= beat + LEN_W'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            opReg    <= i_op;
            lenReg   <= i_len;
            baseAddr <= i_addr;
            wdataReg <= i_wdata;
            // unused upper lanes stay zero for short loads
            o_rdata  <= '0;
        end else if (inFlight) begin
            o_rdata[BYTE_W*capLane +: BYTE_W] <= bus.rdata;
        end
    end

endmodule

//--- rtl/busArbiter.sv
module busArbiter
    import memCtrlPkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              i_rdy,
    input  logic              i_ioBufferFull,
    input  logic [BYTE_W-1:0] i_memRdata,
    output logic              o_memWrite,
    output logic [ADDR_W-1:0] o_memAddr,
    output logic [BYTE_W-1:0] o_memWdata,
    ramBusIf.arbiter          dataBus,
    ramBusIf.arbiter          fetchBus
);

    owner_t owner;
    owner_t activeOwner;
    logic   stall;
    logic   freePort;

    assign stall = !i_rdy || i_ioBufferFull;

    // data wins when both are waiting
    always_comb begin
        activeOwner = owner;
        if (owner == ownNone) begin
            if (dataBus.req) begin
                activeOwner = ownData;
            end else if (fetchBus.req) begin
                activeOwner = ownFetch;
            end
        end
    end

    assign dataBus.gnt  = !stall && (activeOwner == ownData);
    assign fetchBus.gnt = !stall && (activeOwner == ownFetch);

    assign freePort = (dataBus.gnt && dataBus.last) || (fetchBus.gnt && fetchBus.last);

    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= ownNone;
        end else if (!stall) begin
            owner <= freePort ? ownNone : activeOwner;
        end
    end

    // idle port reads address 0
    always_comb begin
        o_memWrite = 1'b0;
        o_memAddr  = '0;
        o_memWdata = '0;
        if (dataBus.gnt) begin
            o_memWrite = dataBus.write;
            o_memAddr  = dataBus.addr;
            o_memWdata = dataBus.wdata;
        end else if (fetchBus.gnt) begin
            o_memWrite = fetchBus.write;
            o_memAddr  = fetchBus.addr;
            o_memWdata = fetchBus.wdata;
        end
    end

    assign dataBus.rdata  = i_memRdata;
    assign fetchBus.rdata = i_memRdata;

endmodule

//--- rtl/memCtrl.sv
module memCtrl
    import memCtrlPkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              i_rdy,
    input  logic              i_ioBufferFull,

    // instruction fetch
    input  logic              i_fetchReq,
    input  logic [ADDR_W-1:0] i_fetchAddr,
    output logic              o_fetchDone,
    output logic [WORD_W-1:0] o_fetchInst,

    // loads and stores
    input  logic              i_dataReq,
    input  accessOp_t         i_dataOp,
    input  accessLen_t        i_dataLen,
    input  logic [ADDR_W-1:0] i_dataAddr,
    input  logic [WORD_W-1:0] i_dataWdata,
    output logic              o_dataDone,
    output logic [WORD_W-1:0] o_dataRdata,

    // external RAM
    output logic              o_memWrite,
    output logic [ADDR_W-1:0] o_memAddr,
    output logic [BYTE_W-1:0] o_memWdata,
    input  logic [BYTE_W-1:0] i_memRdata
);

    ramBusIf fetchBus ();
    ramBusIf dataBus ();

    fetchUnit u_fetchUnit (
        .clk    (clk),
        .rst    (rst),
        .i_req  (i_fetchReq),
        .i_addr (i_fetchAddr),
        .o_done (o_fetchDone),
        .o_inst (o_fetchInst),
        .bus    (fetchBus.requester)
    );

    dataUnit u_dataUnit (
        .clk     (clk),
        .rst     (rst),
        .i_req   (i_dataReq),
        .i_op    (i_dataOp),
        .i_len   (i_dataLen),
        .i_addr  (i_dataAddr),
        .i_wdata (i_dataWdata),
        .o_done  (o_dataDone),
        .o_rdata (o_dataRdata),
        .bus     (dataBus.requester)
    );

    busArbiter u_busArbiter (
        .clk            (clk),
        .rst            (rst),
        .i_rdy          (i_rdy),
        .i_ioBufferFull (i_ioBufferFull),
        .i_memRdata     (i_memRdata),
        .o_memWrite     (o_memWrite),
        .o_memAddr      (o_memAddr),
        .o_memWdata     (o_memWdata),
        .dataBus        (dataBus.arbiter),
        .fetchBus       (fetchBus.arbiter)
    );

endmodule

//--- tb/clockGen.sv
module clockGen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 5;

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

//--- tb/ramModel.sv
module ramModel
    import memCtrlPkg::*;
(
    input  logic              clk,
    input  logic              i_write,
    input  logic [ADDR_W-1:0] i_addr,
    input  logic [BYTE_W-1:0] i_wdata,
    output logic [BYTE_W-1:0] o_rdata,
    input  logic              i_rdy,
    input  logic              i_ioBufferFull,
    output int                o_stallWrites
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MEM_AW   = 10;
    localparam int MEM_SIZE = 1 << MEM_AW;

    logic [BYTE_W-1:0] mem [0:MEM_SIZE-1];

    // every address bit shows up in the byte
    function automatic logic [BYTE_W-1:0] initialByte(input int a);
        return BYTE_W'((a * 37) ^ (a >> 5));
    endfunction

    initial begin
        for (int a = 0; a < MEM_SIZE; a++) begin
            mem[a[MEM_AW-1:0]] <= initialByte(a);
        end
        o_rdata       <= '0;
        o_stallWrites <= 0;
    end

    // one-cycle read, write at the edge
    always @(posedge clk) begin
        if (i_write) begin
            mem[i_addr[MEM_AW-1:0]] <= i_wdata;
            if (!i_rdy || i_ioBufferFull) begin
                o_stallWrites <= o_stallWrites + 1;
                $display("RAM write to %h at %0t ns while the port is stalled", i_addr, $time);
            end
        end else begin
            o_rdata <= mem[i_addr[MEM_AW-1:0]];
        end
    end

endmodule

//--- tb/memCtrlTb.sv
module memCtrlTb
    import memCtrlPkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MEM_AW         = 10;
    localparam int MEM_SIZE       = 1 << MEM_AW;
    localparam int TIMEOUT_CYCLES = 200;
    localparam int STALL_OPS      = 24;

    logic              clk;
    logic              rst;
    logic              i_rdy;
    logic              i_ioBufferFull;
    logic              i_fetchReq;
    logic [ADDR_W-1:0] i_fetchAddr;
    logic              o_fetchDone;
    logic [WORD_W-1:0] o_fetchInst;
    logic              i_dataReq;
    accessOp_t         i_dataOp;
    accessLen_t        i_dataLen;
    logic [ADDR_W-1:0] i_dataAddr;
    logic [WORD_W-1:0] i_dataWdata;
    logic              o_dataDone;
    logic [WORD_W-1:0] o_dataRdata;
    logic              o_memWrite;
    logic [ADDR_W-1:0] o_memAddr;
    logic [BYTE_W-1:0] o_memWdata;
    logic [BYTE_W-1:0] i_memRdata;
    int                stallWrites;

    logic [BYTE_W-1:0] shadow [0:MEM_SIZE-1];
    logic [2:0]        stallPattern [0:255];
    logic              stallOn = 1'b0;
    logic              dataIsLoad [$];
    logic [WORD_W-1:0] dataExp [$];
    logic [WORD_W-1:0] fetchExp [$];
    int                seed = 24;
    int                errorCount = 0;
    int                checkCount = 0;
    int                testCount = 0;
    int                failedTests = 0;
    int                testErrStart;
    int                testCheckStart;
    string             testName;

    clockGen u_clockGen (
        .clk (clk),
        .rst (rst)
    );

    memCtrl u_memCtrl (
        .clk            (clk),
        .rst            (rst),
        .i_rdy          (i_rdy),
        .i_ioBufferFull (i_ioBufferFull),
        .i_fetchReq     (i_fetchReq),
        .i_fetchAddr    (i_fetchAddr),
        .o_fetchDone    (o_fetchDone),
        .o_fetchInst    (o_fetchInst),
        .i_dataReq      (i_dataReq),
        .i_dataOp       (i_dataOp),
        .i_dataLen      (i_dataLen),
        .i_dataAddr     (i_dataAddr),
        .i_dataWdata    (i_dataWdata),
        .o_dataDone     (o_dataDone),
        .o_dataRdata    (o_dataRdata),
        .o_memWrite     (o_memWrite),
        .o_memAddr      (o_memAddr),
        .o_memWdata     (o_memWdata),
        .i_memRdata     (i_memRdata)
    );

    ramModel u_ramModel (
        .clk            (clk),
        .i_write        (o_memWrite),
        .i_addr         (o_memAddr),
        .i_wdata        (o_memWdata),
        .o_rdata        (i_memRdata),
        .i_rdy          (i_rdy),
        .i_ioBufferFull (i_ioBufferFull),
        .o_stallWrites  (stallWrites)
    );

    function automatic logic [BYTE_W-1:0] initialByte(input int a);
        return BYTE_W'((a * 37) ^ (a >> 5));
    endfunction

    // expected little-endian value of nBytes, zero-extended
    function automatic logic [WORD_W-1:0] refRead(input logic [ADDR_W-1:0] addr,
                                                  input int nBytes);
        logic [WORD_W-1:0] value;
        logic [ADDR_W-1:0] a;
        value = '0;
        for (int i = 0; i < nBytes; i++) begin
            a = addr + ADDR_W'(i);
            value[BYTE_W*i +: BYTE_W] = shadow[a[MEM_AW-1:0]];
        end
        return value;
    endfunction

    // leaves room for one byte below and a word above
    function automatic logic [ADDR_W-1:0] randomAddr();
        return ADDR_W'(1 + $unsigned($random(seed)) % (MEM_SIZE - 5));
    endfunction

    function automatic accessLen_t randomLen();
        case ($unsigned($random(seed)) % 3)
            0: return lenByte;
            1: return lenHalf;
            default: return lenWord;
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [WORD_W-1:0] expected,
                              input logic [WORD_W-1:0] actual);
        checkCount++;
        assert (actual === expected) else begin
            $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic reportProblem(input string what);
        errorCount++;
        $display("ERROR at %0t ns: %s", $time, what);
    endtask

    task automatic beginTest(input string name);
        testName       = name;
        testErrStart   = errorCount;
        testCheckStart = checkCount;
    endtask

    task automatic endTest();
        int errs;
        errs = errorCount - testErrStart;
        testCount++;
        if (errs != 0) begin
            failedTests++;
        end
        $display("%s: %0d checks, %0d errors", testName, checkCount - testCheckStart, errs);
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic checkQuiet();
        checkValue("o_fetchDone", '0, WORD_W'(o_fetchDone));
        checkValue("o_dataDone", '0, WORD_W'(o_dataDone));
        checkValue("o_memWrite", '0, WORD_W'(o_memWrite));
    endtask

    task automatic issueData(input accessOp_t op, input accessLen_t len,
                             input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] wdata);
        logic [ADDR_W-1:0] a;
        dataIsLoad.push_back(op == opLoad);
        dataExp.push_back(refRead(addr, int'(len)));
        if (op == opStore) begin
            for (int i = 0; i < int'(len); i++) begin
                a = addr + ADDR_W'(i);
                shadow[a[MEM_AW-1:0]] = wdata[BYTE_W*i +: BYTE_W];
            end
        end
        i_dataOp    = op;
        i_dataLen   = len;
        i_dataAddr  = addr;
        i_dataWdata = wdata;
        i_dataReq   = 1'b1;
    endtask

    task automatic issueFetch(input logic [ADDR_W-1:0] addr);
        fetchExp.push_back(refRead(addr, WORD_BYTES));
        i_fetchAddr = addr;
        i_fetchReq  = 1'b1;
    endtask

    // waits on every raised request, drops each one the cycle after its done
    task automatic waitDone(output int dataAt, output int fetchAt);
        int   cycle;
        logic wantData;
        logic wantFetch;
        wantData  = i_dataReq;
        wantFetch = i_fetchReq;
        dataAt    = -1;
        fetchAt   = -1;
        cycle     = 0;
        while ((wantData || wantFetch) && cycle < TIMEOUT_CYCLES) begin
            @(negedge clk);
            if (wantData && o_dataDone) begin
                dataAt   = cycle;
                wantData = 1'b0;
            end
            if (wantFetch && o_fetchDone) begin
                fetchAt   = cycle;
                wantFetch = 1'b0;
            end
            nextCycle();
            if (!wantData) begin
                i_dataReq = 1'b0;
            end
            if (!wantFetch) begin
                i_fetchReq = 1'b0;
            end
            cycle++;
        end
        assert (!wantData) else begin
            reportProblem("no done within timeout on the data port");
            i_dataReq = 1'b0;
            dataIsLoad.delete();
            dataExp.delete();
        end
        assert (!wantFetch) else begin
            reportProblem("no done within timeout on the fetch port");
            i_fetchReq = 1'b0;
            fetchExp.delete();
        end
    endtask

    task automatic runData(input accessOp_t op, input accessLen_t len,
                           input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] wdata);
        int dataAt;
        int fetchAt;
        issueData(op, len, addr, wdata);
        waitDone(dataAt, fetchAt);
    endtask

    task automatic runFetch(input logic [ADDR_W-1:0] addr);
        int dataAt;
        int fetchAt;
        issueFetch(addr);
        waitDone(dataAt, fetchAt);
    endtask

    // stall pattern is sampled at the edge, driven just after it
    initial begin
        logic       useStall;
        logic [7:0] stallIdx;
        logic [2:0] code;
        i_rdy          = 1'b1;
        i_ioBufferFull = 1'b0;
        stallIdx       = '0;
        forever begin
            @(posedge clk);
            useStall = stallOn;
            #1;
            code = stallPattern[stallIdx];
            if (useStall) begin
                i_rdy          = !(code == 3'd5 || code == 3'd6);
                i_ioBufferFull = (code == 3'd7);
                stallIdx       = stallIdx + 8'd1;
            end else begin
                i_rdy          = 1'b1;
                i_ioBufferFull = 1'b0;
            end
        end
    end

    // compares every done pulse against the queued reference value
    always @(negedge clk) begin : compareDone
        logic              isLoad;
        logic [WORD_W-1:0] expected;
        if (!rst && o_dataDone) begin
            if (dataExp.size() == 0) begin
                reportProblem("data done without a pending request");
            end else begin
                isLoad   = dataIsLoad.pop_front();
                expected = dataExp.pop_front();
                if (isLoad) begin
                    checkValue("o_dataRdata", expected, o_dataRdata);
                end
            end
        end
        if (!rst && o_fetchDone) begin
            if (fetchExp.size() == 0) begin
                reportProblem("fetch done without a pending request");
            end else begin
                expected = fetchExp.pop_front();
                checkValue("o_fetchInst", expected, o_fetchInst);
            end
        end
    end

    initial begin
        int                cycle;
        int                dataAt;
        int                fetchAt;
        int                kind;
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] wdata;
        accessLen_t        len;
        accessLen_t        lens [3];

        i_fetchReq  = 1'b0;
        i_fetchAddr = '0;
        i_dataReq   = 1'b0;
        i_dataOp    = opLoad;
        i_dataLen   = lenByte;
        i_dataAddr  = '0;
        i_dataWdata = '0;
        lens        = '{lenByte, lenHalf, lenWord};
        for (int a = 0; a < MEM_SIZE; a++) begin
            shadow[a[MEM_AW-1:0]] = initialByte(a);
        end

        beginTest("reset");
        cycle = 0;
        while (rst && cycle < TIMEOUT_CYCLES) begin
            @(negedge clk);
            checkQuiet();
            cycle++;
        end
        assert (!rst) else begin
            reportProblem("reset was never released");
        end
        repeat (3) begin
            @(negedge clk);
            checkQuiet();
        end
        nextCycle();
        endTest();

        beginTest("fetch");
        repeat (4) begin
            runFetch(randomAddr());
        end
        endTest();

        beginTest("load");
        foreach (lens[i]) begin
            runData(opLoad, lens[i], randomAddr(), '0);
        end
        endTest();

        // word load shows bytes above, byte load the one below
        beginTest("store");
        foreach (lens[i]) begin
            addr  = randomAddr();
            wdata = WORD_W'($random(seed));
            runData(opStore, lens[i], addr, wdata);
            runData(opLoad, lenWord, addr, '0);
            runData(opLoad, lenByte, addr - ADDR_W'(1), '0);
        end
        endTest();

        beginTest("priority");
        for (int r = 0; r < 2; r++) begin
            addr  = randomAddr();
            wdata = WORD_W'($random(seed));
            if (r == 0) begin
                issueData(opLoad, lenWord, addr, '0);
            end else begin
                issueData(opStore, lenHalf, addr, wdata);
            end
            issueFetch(randomAddr());
            waitDone(dataAt, fetchAt);
            checkCount++;
            assert (dataAt >= 0 && fetchAt > dataAt) else begin
                reportProblem("data done did not arrive before fetch done");
            end
        end
        endTest();

        beginTest("stall");
        for (int i = 0; i < 256; i++) begin
            stallPattern[i[7:0]] = 3'($random(seed));
        end
        stallOn = 1'b1;
        for (int n = 0; n < STALL_OPS; n++) begin
            kind  = $unsigned($random(seed)) % 3;
            len   = randomLen();
            addr  = randomAddr();
            wdata = WORD_W'($random(seed));
            case (kind)
                0: runFetch(addr);
                1: runData(opLoad, len, addr, '0);
                default: runData(opStore, len, addr, wdata);
            endcase
        end
        stallOn = 1'b0;
        nextCycle();
        checkValue("stalled RAM writes", '0, WORD_W'(stallWrites));
        endTest();

        $display("tests %0d, failing tests %0d, checks %0d, errors %0d",
                 testCount, failedTests, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- sources.f
rtl/memCtrlPkg.sv
rtl/ramBusIf.sv
rtl/fetchUnit.sv
rtl/dataUnit.sv
rtl/busArbiter.sv
rtl/memCtrl.sv
tb/clockGen.sv
tb/ramModel.sv
tb/memCtrlTb.sv

//--- run.sh
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f sources.f --top-module memCtrlTb -o memCtrlSim \
    && ./obj_dir/memCtrlSim | tee sim.log \
    || { echo "build or simulation error"; exit 1; }

grep -qx "Test passed" sim.log \
    && echo "simulation result: pass" \
    || { echo "simulation result: fail"; exit 1; }
